// File: hdl/generals_pkg.sv
package generals_pkg;

    // board geometry
    localparam int BOARD_WIDTH = 10;
    localparam int CELL_COUNT = BOARD_WIDTH * BOARD_WIDTH;
    localparam int COORD_W = 4;
    localparam int TROOP_W = 9;
    localparam int STEP_W = 12;
    localparam int GROWTH_PERIOD = 16;

    localparam logic [COORD_W-1:0] RED_CROWN_H = 4'd2;
    localparam logic [COORD_W-1:0] RED_CROWN_V = 4'd3;
    localparam logic [COORD_W-1:0] BLUE_CROWN_H = 4'd8;
    localparam logic [COORD_W-1:0] BLUE_CROWN_V = 4'd7;

    // opening troop values
    localparam logic [TROOP_W-1:0] RED_CROWN_TROOP = 9'd87;
    localparam logic [TROOP_W-1:0] BLUE_CROWN_TROOP = 9'd89;
    localparam logic [TROOP_W-1:0] RED_CITY_TROOP = 9'd25;
    localparam logic [TROOP_W-1:0] BLUE_CITY_TROOP = 9'd37;

    typedef enum logic [1:0] {NPC, RED, BLUE} player_t;
    typedef enum logic [1:0] {TERRITORY, MOUNTAIN, CROWN, CITY} piece_t;

    // bit 1 set means a move mode
    typedef enum logic [1:0] {
        CHOOSE     = 2'b00,
        MOVE_TOTAL = 2'b10,
        MOVE_HALF  = 2'b11
    } cursor_mode_t;

    // codes 6 and 7 are illegal
    typedef enum logic [2:0] {
        UP          = 3'd0,
        LEFT        = 3'd1,
        DOWN        = 3'd2,
        RIGHT       = 3'd3,
        SELECT      = 3'd4,
        HALF_TOGGLE = 3'd5
    } key_op_t;

    typedef enum logic [2:0] {READY, IN_ROUND, CHECK_WIN, ROUND_SWITCH, GAME_OVER} game_state_t;
    typedef enum logic [1:0] {GROW_NONE, GROW_CITIES, GROW_ALL} grow_t;

    // opening layout, first match wins
    function automatic void opening_cell(
        input  int                 h,
        input  int                 v,
        output player_t            owner,
        output piece_t             piece,
        output logic [TROOP_W-1:0] troop
    );
        owner = NPC;
        piece = TERRITORY;
        troop = '0;
        if (h == RED_CROWN_H && v == RED_CROWN_V) begin
            owner = RED;
            piece = CROWN;
            troop = RED_CROWN_TROOP;
        end else if (h == BLUE_CROWN_H && v == BLUE_CROWN_V) begin
            owner = BLUE;
            piece = CROWN;
            troop = BLUE_CROWN_TROOP;
        end else if (v == 5) begin
            piece = CITY;
        end else if (h + v == 9 && h >= 6) begin
            piece = MOUNTAIN;
        end else if (h >= 2 && h <= 5 && v >= 2 && v <= 5) begin
            owner = RED;
            piece = CITY;
            troop = RED_CITY_TROOP;
        end else if (h >= 7 && v >= 5) begin
            owner = BLUE;
            piece = CITY;
            troop = BLUE_CITY_TROOP;
        end
    endfunction

endpackage

// File: hdl/key_receiver.sv
`timescale 1ns/1ps

module key_receiver (
    input  logic                  clk_100M,
    input  logic                  reset,
    input  logic                  key_req,
    input  logic [2:0]            key_op,
    output logic                  key_ack,
    output logic                  op_valid,
    output generals_pkg::key_op_t op,
    input  logic                  op_taken
);
    import generals_pkg::*;

    typedef enum logic {HS_IDLE, HS_ACK} hs_state_t;

    hs_state_t hs_state;
    logic      capture;
    logic      legal;

    // a new request is only accepted once the last op was consumed
    assign capture = (hs_state == HS_IDLE) && key_req && !op_valid;
    assign legal = key_op <= HALF_TOGGLE;
    assign key_ack = (hs_state == HS_ACK);

    always_ff @(posedge clk_100M or posedge reset) begin
        if (reset) begin
            hs_state <= HS_IDLE;
            op_valid <= 1'b0;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (capture) begin
                        hs_state <= HS_ACK;
                    end
                end
                default: begin
                    // wait for the source to drop req
                    if (!key_req) begin
                        hs_state <= HS_IDLE;
                    end
                end
            endcase
            // illegal codes get an ack but never become pending
            if (capture && legal) begin
                op_valid <= 1'b1;
            end else if (op_taken) begin
                op_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_100M) begin
        if (capture && legal) begin
            op <= key_op_t'(key_op);
        end
    end

    // the source keeps the op stable for as long as req is high
    a_op_stable: assert property (@(posedge clk_100M) disable iff (reset)
        key_req && $past(key_req) |-> $stable(key_op));

endmodule

// File: hdl/game_controller.sv
`timescale 1ns/1ps

module game_controller (
    input  logic                                clk_100M,
    input  logic                                reset,
    input  logic                                start,
    input  logic                                op_valid,
    input  generals_pkg::key_op_t               op,
    output logic                                op_taken,
    input  generals_pkg::player_t               cur_owner,
    input  generals_pkg::piece_t                cur_piece,
    input  logic [generals_pkg::TROOP_W-1:0]    cur_troop,
    input  generals_pkg::player_t               dst_owner,
    input  generals_pkg::piece_t                dst_piece,
    input  logic [generals_pkg::TROOP_W-1:0]    dst_troop,
    input  logic                                red_crown_lost,
    input  logic                                blue_crown_lost,
    output logic                                load,
    output logic                                move_en,
    output logic [generals_pkg::COORD_W-1:0]    src_h,
    output logic [generals_pkg::COORD_W-1:0]    src_v,
    output logic [generals_pkg::COORD_W-1:0]    dst_h,
    output logic [generals_pkg::COORD_W-1:0]    dst_v,
    output logic [generals_pkg::TROOP_W-1:0]    dispatch,
    output generals_pkg::player_t               mover,
    output generals_pkg::grow_t                 grow,
    output logic [generals_pkg::COORD_W-1:0]    cursor_h,
    output logic [generals_pkg::COORD_W-1:0]    cursor_v,
    output generals_pkg::cursor_mode_t          cursor_mode,
    output generals_pkg::player_t               current_player,
    output logic                                game_over,
    output generals_pkg::player_t               winner
);
    import generals_pkg::*;

    localparam logic [COORD_W-1:0] EDGE = COORD_W'(BOARD_WIDTH - 1);

    game_state_t        state;
    logic [STEP_W-1:0]  step_cnt;
    logic [STEP_W-1:0]  round_num;
    logic               attack;
    logic               target_ok;

    // the source of a move is always the cursor cell
    assign src_h = cursor_h;
    assign src_v = cursor_v;
    assign mover = current_player;
    assign game_over = (state == GAME_OVER);
    assign load = (state == READY) && start;
    assign round_num = (step_cnt + 1'b1) >> 1;

    // ops arriving before start or after the end are dropped
    assign op_taken = op_valid && ((state == IN_ROUND && !move_en) ||
                                   state == READY || state == GAME_OVER);

    // clamped neighbour of the cursor in the direction of op
    // op stays put until the next capture
    always_comb begin
        dst_h = cursor_h;
        dst_v = cursor_v;
        case (op)
            UP:      dst_v = (cursor_v == '0) ? cursor_v : cursor_v - 1'b1;
            LEFT:    dst_h = (cursor_h == '0) ? cursor_h : cursor_h - 1'b1;
            DOWN:    dst_v = (cursor_v == EDGE) ? cursor_v : cursor_v + 1'b1;
            RIGHT:   dst_h = (cursor_h == EDGE) ? cursor_h : cursor_h + 1'b1;
            default: ;
        endcase
    end

    assign target_ok = {dst_h, dst_v} != {cursor_h, cursor_v};

    // only the value latched on the take edge reaches the cells
    always_ff @(posedge clk_100M) begin
        dispatch <= (cursor_mode == MOVE_HALF) ? cur_troop >> 1 : cur_troop - 1'b1;
    end

    always_ff @(posedge clk_100M or posedge reset) begin
        if (reset) begin
            state <= READY;
            cursor_h <= '0;
            cursor_v <= '0;
            cursor_mode <= CHOOSE;
            current_player <= NPC;
            step_cnt <= '0;
            winner <= NPC;
            move_en <= 1'b0;
            attack <= 1'b0;
            grow <= GROW_NONE;
        end else begin
            move_en <= 1'b0;
            grow <= GROW_NONE;
            case (state)
                READY: begin
                    if (start) begin
                        state <= IN_ROUND;
                        current_player <= RED;
                        cursor_h <= RED_CROWN_H;
                        cursor_v <= RED_CROWN_V;
                        cursor_mode <= CHOOSE;
                        step_cnt <= '0;
                        winner <= NPC;
                    end
                end
                IN_ROUND: begin
                    if (move_en) begin
                        // cells take the move on this edge
                        state <= attack ? CHECK_WIN : ROUND_SWITCH;
                    end else if (op_valid) begin
                        if (cursor_mode == CHOOSE) begin
                            if (op == SELECT) begin
                                if (cur_owner == current_player && cur_troop >= 2) begin
                                    cursor_mode <= MOVE_TOTAL;
                                end
                            end else if (target_ok) begin
                                cursor_h <= dst_h;
                                cursor_v <= dst_v;
                            end
                        end else if (op == SELECT) begin
                            cursor_mode <= CHOOSE;
                        end else if (op == HALF_TOGGLE) begin
                            cursor_mode <= (cursor_mode == MOVE_TOTAL) ? MOVE_HALF : MOVE_TOTAL;
                        end else if (target_ok && dst_piece != MOUNTAIN) begin
                            move_en <= 1'b1;
                            attack <= (dst_owner != NPC) && (dst_owner != current_player);
                        end
                    end
                end
                CHECK_WIN: begin
                    if (red_crown_lost) begin
                        winner <= BLUE;
                        state <= GAME_OVER;
                    end else if (blue_crown_lost) begin
                        winner <= RED;
                        state <= GAME_OVER;
                    end else begin
                        state <= ROUND_SWITCH;
                    end
                end
                ROUND_SWITCH: begin
                    state <= IN_ROUND;
                    cursor_mode <= CHOOSE;
                    step_cnt <= step_cnt + 1'b1;
                    if (current_player == RED) begin
                        current_player <= BLUE;
                        cursor_h <= BLUE_CROWN_H;
                        cursor_v <= BLUE_CROWN_V;
                    end else begin
                        current_player <= RED;
                        cursor_h <= RED_CROWN_H;
                        cursor_v <= RED_CROWN_V;
                    end
                    // growth at the end of every full round
                    if (step_cnt[0]) begin
                        grow <= (round_num % GROWTH_PERIOD == 0) ? GROW_ALL : GROW_CITIES;
                    end
                end
                default: ;
            endcase
        end
    end

    // the cursor square stays the player's own for the whole move mode
    a_mode_owner: assert property (@(posedge clk_100M) disable iff (reset)
        cursor_mode != CHOOSE |-> cur_owner == current_player && cur_piece != MOUNTAIN);

    // a crown can only be lost by the capture that was just made
    a_crown_capture: assert property (@(posedge clk_100M) disable iff (reset)
        state == CHECK_WIN && (red_crown_lost || blue_crown_lost) |->
        $past(dispatch > dst_troop));

endmodule

// File: hdl/board_cell.sv
`timescale 1ns/1ps

module board_cell #(
    parameter int CELL_H = 0,
    parameter int CELL_V = 0
) (
    input  logic                                clk_100M,
    input  logic                                reset,
    input  logic                                load,
    input  logic                                move_en,
    input  logic [generals_pkg::COORD_W-1:0]    src_h,
    input  logic [generals_pkg::COORD_W-1:0]    src_v,
    input  logic [generals_pkg::COORD_W-1:0]    dst_h,
    input  logic [generals_pkg::COORD_W-1:0]    dst_v,
    input  logic [generals_pkg::TROOP_W-1:0]    dispatch,
    input  generals_pkg::player_t               mover,
    input  generals_pkg::grow_t                 grow,
    output generals_pkg::player_t               owner,
    output generals_pkg::piece_t                piece,
    output logic [generals_pkg::TROOP_W-1:0]    troop
);
    import generals_pkg::*;

    localparam logic [COORD_W-1:0] MY_H = COORD_W'(CELL_H);
    localparam logic [COORD_W-1:0] MY_V = COORD_W'(CELL_V);

    player_t            open_owner;
    piece_t             open_piece;
    logic [TROOP_W-1:0] open_troop;
    logic               is_src;
    logic               is_dst;
    logic               grows;

    always_comb begin
        opening_cell(CELL_H, CELL_V, open_owner, open_piece, open_troop);
    end

    assign is_src = move_en && src_h == MY_H && src_v == MY_V;
    assign is_dst = move_en && dst_h == MY_H && dst_v == MY_V;

    // cities and crowns grow every round, all owned squares on GROW_ALL
    assign grows = (owner != NPC) &&
                   (grow == GROW_ALL || (grow == GROW_CITIES && (piece == CITY || piece == CROWN)));

    always_ff @(posedge clk_100M or posedge reset) begin
        if (reset) begin
            owner <= NPC;
            piece <= TERRITORY;
            troop <= '0;
        end else if (load) begin
            owner <= open_owner;
            piece <= open_piece;
            troop <= open_troop;
        end else if (is_src) begin
            troop <= troop - dispatch;
        end else if (is_dst) begin
            if (owner == mover) begin
                troop <= troop + dispatch;
            end else if (dispatch > troop) begin
                // captured
                owner <= mover;
                troop <= dispatch - troop;
            end else begin
                troop <= troop - dispatch;
            end
        end else if (grows) begin
            troop <= troop + 1'b1;
        end
    end

    a_no_underflow: assert property (@(posedge clk_100M) disable iff (reset)
        is_src |-> troop >= dispatch);

endmodule

// File: hdl/board_reader.sv
`timescale 1ns/1ps

module board_reader (
    input  generals_pkg::player_t               cell_owner [generals_pkg::CELL_COUNT],
    input  generals_pkg::piece_t                cell_piece [generals_pkg::CELL_COUNT],
    input  logic [generals_pkg::TROOP_W-1:0]    cell_troop [generals_pkg::CELL_COUNT],
    input  logic [generals_pkg::COORD_W-1:0]    cursor_h,
    input  logic [generals_pkg::COORD_W-1:0]    cursor_v,
    input  logic [generals_pkg::COORD_W-1:0]    dst_h,
    input  logic [generals_pkg::COORD_W-1:0]    dst_v,
    output generals_pkg::player_t               cur_owner,
    output generals_pkg::piece_t                cur_piece,
    output logic [generals_pkg::TROOP_W-1:0]    cur_troop,
    output generals_pkg::player_t               dst_owner,
    output generals_pkg::piece_t                dst_piece,
    output logic [generals_pkg::TROOP_W-1:0]    dst_troop,
    output logic                                red_crown_lost,
    output logic                                blue_crown_lost
);
    import generals_pkg::*;

    localparam int RED_CROWN_IDX = RED_CROWN_H * BOARD_WIDTH + RED_CROWN_V;
    localparam int BLUE_CROWN_IDX = BLUE_CROWN_H * BOARD_WIDTH + BLUE_CROWN_V;

    int cur_idx;
    int dst_idx;

    // cells are laid out h-major
    assign cur_idx = cursor_h * BOARD_WIDTH + cursor_v;
    assign dst_idx = dst_h * BOARD_WIDTH + dst_v;

    assign cur_owner = cell_owner[cur_idx];
    assign cur_piece = cell_piece[cur_idx];
    assign cur_troop = cell_troop[cur_idx];
    assign dst_owner = cell_owner[dst_idx];
    assign dst_piece = cell_piece[dst_idx];
    assign dst_troop = cell_troop[dst_idx];

    assign red_crown_lost = cell_owner[RED_CROWN_IDX] != RED;
    assign blue_crown_lost = cell_owner[BLUE_CROWN_IDX] != BLUE;

endmodule

// File: hdl/game_top.sv
`timescale 1ns/1ps

module game_top (
    input  logic                                clk_100M,
    input  logic                                reset,
    input  logic                                start,
    input  logic                                key_req,
    input  logic [2:0]                          key_op,
    output logic                                key_ack,
    output logic [generals_pkg::COORD_W-1:0]    cursor_h,
    output logic [generals_pkg::COORD_W-1:0]    cursor_v,
    output generals_pkg::cursor_mode_t          cursor_mode,
    output generals_pkg::player_t               current_player,
    output generals_pkg::player_t               cursor_owner,
    output generals_pkg::piece_t                cursor_piece,
    output logic [generals_pkg::TROOP_W-1:0]    cursor_troop,
    output logic                                game_over,
    output generals_pkg::player_t               winner
);
    import generals_pkg::*;

    logic               op_valid;
    logic               op_taken;
    key_op_t            op;
    player_t            dst_owner;
    piece_t             dst_piece;
    logic [TROOP_W-1:0] dst_troop;
    logic               red_crown_lost;
    logic               blue_crown_lost;
    logic               load;
    logic               move_en;
    logic [COORD_W-1:0] src_h;
    logic [COORD_W-1:0] src_v;
    logic [COORD_W-1:0] dst_h;
    logic [COORD_W-1:0] dst_v;
    logic [TROOP_W-1:0] dispatch;
    player_t            mover;
    grow_t              grow;
    player_t            cell_owner [CELL_COUNT];
    piece_t             cell_piece [CELL_COUNT];
    logic [TROOP_W-1:0] cell_troop [CELL_COUNT];

    key_receiver u_keys (
        .clk_100M(clk_100M),
        .reset(reset),
        .key_req(key_req),
        .key_op(key_op),
        .key_ack(key_ack),
        .op_valid(op_valid),
        .op(op),
        .op_taken(op_taken)
    );

    game_controller u_ctrl (
        .clk_100M(clk_100M),
        .reset(reset),
        .start(start),
        .op_valid(op_valid),
        .op(op),
        .op_taken(op_taken),
        .cur_owner(cursor_owner),
        .cur_piece(cursor_piece),
        .cur_troop(cursor_troop),
        .dst_owner(dst_owner),
        .dst_piece(dst_piece),
        .dst_troop(dst_troop),
        .red_crown_lost(red_crown_lost),
        .blue_crown_lost(blue_crown_lost),
        .load(load),
        .move_en(move_en),
        .src_h(src_h),
        .src_v(src_v),
        .dst_h(dst_h),
        .dst_v(dst_v),
        .dispatch(dispatch),
        .mover(mover),
        .grow(grow),
        .cursor_h(cursor_h),
        .cursor_v(cursor_v),
        .cursor_mode(cursor_mode),
        .current_player(current_player),
        .game_over(game_over),
        .winner(winner)
    );

    // one square per instance, index h*BOARD_WIDTH+v
    for (genvar i = 0; i < CELL_COUNT; i++) begin : g_cell
        board_cell #(
            .CELL_H(i / BOARD_WIDTH),
            .CELL_V(i % BOARD_WIDTH)
        ) u_cell (
            .clk_100M(clk_100M),
            .reset(reset),
            .load(load),
            .move_en(move_en),
            .src_h(src_h),
            .src_v(src_v),
            .dst_h(dst_h),
            .dst_v(dst_v),
            .dispatch(dispatch),
            .mover(mover),
            .grow(grow),
            .owner(cell_owner[i]),
            .piece(cell_piece[i]),
            .troop(cell_troop[i])
        );
    end

    board_reader u_reader (
        .cell_owner(cell_owner),
        .cell_piece(cell_piece),
        .cell_troop(cell_troop),
        .cursor_h(cursor_h),
        .cursor_v(cursor_v),
        .dst_h(dst_h),
        .dst_v(dst_v),
        .cur_owner(cursor_owner),
        .cur_piece(cursor_piece),
        .cur_troop(cursor_troop),
        .dst_owner(dst_owner),
        .dst_piece(dst_piece),
        .dst_troop(dst_troop),
        .red_crown_lost(red_crown_lost),
        .blue_crown_lost(blue_crown_lost)
    );

endmodule

// File: test/board_model.svh
`ifndef BOARD_MODEL_SVH
`define BOARD_MODEL_SVH

// reference board, indexed h*BOARD_WIDTH+v
player_t            m_owner [CELL_COUNT];
piece_t             m_piece [CELL_COUNT];
logic [TROOP_W-1:0] m_troop [CELL_COUNT];
int                 m_cur_h;
int                 m_cur_v;
cursor_mode_t       m_mode;
player_t            m_player;
player_t            m_winner;
bit                 m_started;
bit                 m_over;
int                 m_step;

function automatic int cell_index(input int h, input int v);
    return h * BOARD_WIDTH + v;
endfunction

function automatic void model_reset();
    for (int i = 0; i < CELL_COUNT; i++) begin
        m_owner[i] = NPC;
        m_piece[i] = TERRITORY;
        m_troop[i] = '0;
    end
    m_cur_h = 0;
    m_cur_v = 0;
    m_mode = CHOOSE;
    m_player = NPC;
    m_winner = NPC;
    m_started = 0;
    m_over = 0;
    m_step = 0;
endfunction

// opening layout, first rule that matches wins
function automatic void model_load();
    int i;
    for (int h = 0; h < BOARD_WIDTH; h++) begin
        for (int v = 0; v < BOARD_WIDTH; v++) begin
            i = cell_index(h, v);
            m_owner[i] = NPC;
            m_piece[i] = TERRITORY;
            m_troop[i] = '0;
            if (h == 2 && v == 3) begin
                m_owner[i] = RED;
                m_piece[i] = CROWN;
                m_troop[i] = 87;
            end else if (h == 8 && v == 7) begin
                m_owner[i] = BLUE;
                m_piece[i] = CROWN;
                m_troop[i] = 89;
            end else if (v == 5) begin
                m_piece[i] = CITY;
            end else if (h + v == 9 && h >= 6) begin
                m_piece[i] = MOUNTAIN;
            end else if (h >= 2 && h <= 5 && v >= 2 && v <= 5) begin
                m_owner[i] = RED;
                m_piece[i] = CITY;
                m_troop[i] = 25;
            end else if (h >= 7 && v >= 5) begin
                m_owner[i] = BLUE;
                m_piece[i] = CITY;
                m_troop[i] = 37;
            end
        end
    end
    m_player = RED;
    m_cur_h = 2;
    m_cur_v = 3;
    m_mode = CHOOSE;
    m_step = 0;
    m_winner = NPC;
    m_started = 1;
endfunction

function automatic void model_grow(input bit all_cells);
    for (int i = 0; i < CELL_COUNT; i++) begin
        if (m_owner[i] != NPC && (all_cells || m_piece[i] == CITY || m_piece[i] == CROWN)) begin
            m_troop[i] = m_troop[i] + 1'b1;
        end
    end
endfunction

function automatic void model_switch();
    int round;
    // a full round ends after every second step
    if (m_step % 2 == 1) begin
        round = (m_step + 1) / 2;
        model_grow(round % GROWTH_PERIOD == 0);
    end
    m_step++;
    m_mode = CHOOSE;
    if (m_player == RED) begin
        m_player = BLUE;
        m_cur_h = 8;
        m_cur_v = 7;
    end else begin
        m_player = RED;
        m_cur_h = 2;
        m_cur_v = 3;
    end
endfunction

function automatic void model_move(input int th, input int tv);
    int                 src;
    int                 dst;
    logic [TROOP_W-1:0] send;
    bit                 hit_enemy;
    src = cell_index(m_cur_h, m_cur_v);
    dst = cell_index(th, tv);
    send = (m_mode == MOVE_HALF) ? m_troop[src] >> 1 : m_troop[src] - 1'b1;
    hit_enemy = m_owner[dst] != NPC && m_owner[dst] != m_player;
    m_troop[src] = m_troop[src] - send;
    if (m_owner[dst] == m_player) begin
        m_troop[dst] = m_troop[dst] + send;
    end else if (send > m_troop[dst]) begin
        m_owner[dst] = m_player;
        m_troop[dst] = send - m_troop[dst];
    end else begin
        m_troop[dst] = m_troop[dst] - send;
    end
    if (hit_enemy) begin
        if (m_owner[cell_index(2, 3)] != RED) begin
            m_winner = BLUE;
            m_over = 1;
        end else if (m_owner[cell_index(8, 7)] != BLUE) begin
            m_winner = RED;
            m_over = 1;
        end
    end
    if (!m_over) begin
        model_switch();
    end
endfunction

function automatic void model_apply_op(input int code);
    int nh;
    int nv;
    int idx;
    // illegal codes and ops outside a running game do nothing
    if (code > 5 || !m_started || m_over) begin
        return;
    end
    nh = m_cur_h;
    nv = m_cur_v;
    idx = cell_index(m_cur_h, m_cur_v);
    case (code)
        0: nv = (nv > 0) ? nv - 1 : nv;
        1: nh = (nh > 0) ? nh - 1 : nh;
        2: nv = (nv < BOARD_WIDTH - 1) ? nv + 1 : nv;
        3: nh = (nh < BOARD_WIDTH - 1) ? nh + 1 : nh;
        default: ;
    endcase
    if (m_mode == CHOOSE) begin
        if (code == 4) begin
            if (m_owner[idx] == m_player && m_troop[idx] >= 2) begin
                m_mode = MOVE_TOTAL;
            end
        end else begin
            m_cur_h = nh;
            m_cur_v = nv;
        end
    end else if (code == 4) begin
        m_mode = CHOOSE;
    end else if (code == 5) begin
        m_mode = (m_mode == MOVE_TOTAL) ? MOVE_HALF : MOVE_TOTAL;
    end else if ((nh != m_cur_h || nv != m_cur_v) && m_piece[cell_index(nh, nv)] != MOUNTAIN) begin
        model_move(nh, nv);
    end
endfunction

`endif

// File: test/game_tb.sv
`timescale 1ns/1ps

module game_tb;
    import generals_pkg::*;

    localparam int NUM_OPS = 400;
    // about 8 cycles per op, limit leaves plenty of margin
    localparam int MAX_CYCLES = NUM_OPS * 20 + 100;

    logic               clk_100M;
    logic               reset;
    logic               start;
    logic               key_req;
    logic [2:0]         key_op;
    logic               key_ack;
    logic [COORD_W-1:0] cursor_h;
    logic [COORD_W-1:0] cursor_v;
    cursor_mode_t       cursor_mode;
    player_t            current_player;
    player_t            cursor_owner;
    piece_t             cursor_piece;
    logic [TROOP_W-1:0] cursor_troop;
    logic               game_over;
    player_t            winner;
    int                 seed;
    int                 op_count;
    int                 cycle_count;
    string              test_name;

    `include "board_model.svh"

    game_top uut (
        .clk_100M(clk_100M),
        .reset(reset),
        .start(start),
        .key_req(key_req),
        .key_op(key_op),
        .key_ack(key_ack),
        .cursor_h(cursor_h),
        .cursor_v(cursor_v),
        .cursor_mode(cursor_mode),
        .current_player(current_player),
        .cursor_owner(cursor_owner),
        .cursor_piece(cursor_piece),
        .cursor_troop(cursor_troop),
        .game_over(game_over),
        .winner(winner)
    );

    always #5 clk_100M = ~clk_100M;

    always @(posedge clk_100M) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run passed the limit of %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Error: test %s, %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_outputs();
        int idx;
        idx = cell_index(m_cur_h, m_cur_v);
        check_value("key_ack", 0, int'(key_ack));
        check_value("cursor_h", m_cur_h, int'(cursor_h));
        check_value("cursor_v", m_cur_v, int'(cursor_v));
        check_value("cursor_mode", int'(m_mode), int'(cursor_mode));
        check_value("current_player", int'(m_player), int'(current_player));
        check_value("cursor_owner", int'(m_owner[idx]), int'(cursor_owner));
        check_value("cursor_piece", int'(m_piece[idx]), int'(cursor_piece));
        check_value("cursor_troop", int'(m_troop[idx]), int'(cursor_troop));
        check_value("game_over", int'(m_over), int'(game_over));
        check_value("winner", int'(m_winner), int'(winner));
    endtask

    // full four-phase handshake, entered and left 1 ns after a rising edge
    task automatic send_op(input logic [2:0] code);
        key_op = code;
        key_req = 1'b1;
        @(negedge clk_100M);
        while (!key_ack) @(negedge clk_100M);
        @(posedge clk_100M);
        #1;
        key_req = 1'b0;
        @(negedge clk_100M);
        while (key_ack) @(negedge clk_100M);
        // every effect has landed 4 cycles after ack falls
        repeat (4) @(negedge clk_100M);
        model_apply_op(int'(code));
        op_count++;
        check_outputs();
        @(posedge clk_100M);
        #1;
    endtask

    // mostly directions, some mode keys, a few illegal codes
    function automatic logic [2:0] random_op();
        int r;
        r = $unsigned($random(seed)) % 100;
        if (r < 66) begin
            return 3'(r % 4);
        end else if (r < 84) begin
            return 3'd4;
        end else if (r < 94) begin
            return 3'd5;
        end
        return 3'(6 + r % 2);
    endfunction

    initial begin
        clk_100M = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        key_req = 1'b0;
        key_op = '0;
        seed = 5;
        op_count = 0;
        cycle_count = 0;

        test_name = "reset";
        model_reset();
        repeat (2) @(posedge clk_100M);
        #1;
        reset = 1'b0;
        @(negedge clk_100M);
        check_outputs();

        test_name = "start";
        @(posedge clk_100M);
        #1;
        start = 1'b1;
        @(posedge clk_100M);
        #1;
        start = 1'b0;
        model_load();
        @(negedge clk_100M);
        check_outputs();
        check_value("opening crown troop", 87, int'(cursor_troop));
        check_value("opening player", int'(RED), int'(current_player));
        @(posedge clk_100M);
        #1;

        // corner first, with two clamped moves, then a snake over all cells
        test_name = "layout_walk";
        repeat (2) send_op(LEFT);
        repeat (4) send_op(UP);
        send_op(LEFT);
        for (int h = 0; h < BOARD_WIDTH; h++) begin
            repeat (BOARD_WIDTH - 1) send_op((h % 2 == 0) ? DOWN : UP);
            if (h < BOARD_WIDTH - 1) begin
                send_op(RIGHT);
            end
        end

        // start outside READY is ignored
        test_name = "start_ignored";
        start = 1'b1;
        @(posedge clk_100M);
        #1;
        start = 1'b0;
        @(negedge clk_100M);
        check_outputs();
        @(posedge clk_100M);
        #1;

        test_name = "random_ops";
        while (op_count < NUM_OPS) begin
            send_op(random_op());
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: sources.f
+incdir+test
hdl/generals_pkg.sv
hdl/key_receiver.sv
hdl/game_controller.sv
hdl/board_cell.sv
hdl/board_reader.sv
hdl/game_top.sv
test/game_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the game testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module game_tb \
    -o game_tb_sim
./obj_dir/game_tb_sim
